//--- Makefile
# Verilator build and run of the decoder front-end testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f compile.f --top-module viterbiFrontEndTb
	./obj_dir/VviterbiFrontEndTb | tee $(LOG)
	@grep -qx "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- compile.f
+incdir+design
+incdir+tests
design/viterbiPkg.sv
design/softDecisionMapper.sv
design/codePairer.sv
design/sprtSyncDetector.sv
design/viterbiFrontEnd.sv
tests/viterbiFrontEndTb.sv

//--- design/codePairer.sv
`timescale 1ns/10ps

module codePairer
    import viterbiPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       i_symEn,
    input  demodMode_t i_mode,
    input  softDec_t   i_iSoft,
    input  softDec_t   i_qSoft,
    input  logic       i_outOfSync,
    output logic       o_pairEn,
    output softDec_t   o_iG1,
    output softDec_t   o_iG2,
    output softDec_t   o_qG1,
    output softDec_t   o_qG2,
    output pairState_t o_pairState
);

    localparam int SoftWidth = $bits(softDec_t);

    logic       codeToggle;
    logic       stepPending;
    demodMode_t modeQ;
    logic       modeChange;
    logic       stepNow;
    softDec_t   iSoftDly;
    softDec_t   g1Sel;
    softDec_t   g2Sel;
    logic       capture;
    logic       flip;
    logic       g2First;
    logic       g2Inv;

    assign modeChange = (i_mode != modeQ);

    // BPSK may only step on a G1 boundary
    assign stepNow = i_symEn && (i_outOfSync || stepPending) &&
                     ((i_mode == MODE_QPSK) || codeToggle);

    assign g2Inv   = o_pairState[2];
    assign flip    = o_pairState[1];
    assign g2First = o_pairState[0];

    always_comb begin
        if (i_mode == MODE_QPSK) begin
            capture = 1'b1;
            case (o_pairState[1:0])
                2'd0: begin
                    g1Sel = i_iSoft;
                    g2Sel = i_qSoft;
                end
                2'd1: begin
                    g1Sel = i_qSoft;
                    g2Sel = ~i_iSoft;
                end
                2'd2: begin
                    g1Sel = ~i_iSoft;
                    g2Sel = ~i_qSoft;
                end
                default: begin
                    g1Sel = ~i_qSoft;
                    g2Sel = i_iSoft;
                end
            endcase
            g2Sel = g2Sel ^ {SoftWidth{g2Inv}};
        end
        else begin
            // Consecutive I decisions, aligned by the toggle
            capture = g2First ? !codeToggle : codeToggle;
            g1Sel   = iSoftDly ^ {SoftWidth{flip}};
            g2Sel   = i_iSoft ^ {SoftWidth{flip ^ g2Inv}};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            codeToggle  <= 1'b0;
            o_pairEn    <= 1'b0;
            stepPending <= 1'b0;
            modeQ       <= i_mode;
            o_pairState <= P0;
        end
        else begin
            modeQ    <= i_mode;
            o_pairEn <= i_symEn & codeToggle;

            if (i_mode == MODE_QPSK) begin
                codeToggle <= 1'b1;
            end
            else if (i_symEn) begin
                codeToggle <= ~codeToggle;
            end

            // Out-of-sync pulse is held until a strobe can act on it
            if (modeChange) begin
                o_pairState <= P0;
                stepPending <= 1'b0;
            end
            else if (stepNow) begin
                o_pairState <= pairState_t'(o_pairState + 3'd1);
                stepPending <= 1'b0;
            end
            else if (i_outOfSync) begin
                stepPending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_symEn) begin
            iSoftDly <= i_iSoft;
        end
        if (i_symEn && capture) begin
            o_iG1 <= g1Sel;
            o_iG2 <= g2Sel;
            if (i_mode == MODE_QPSK) begin
                o_qG1 <= g1Sel;
                o_qG2 <= g2Sel;
            end
            else begin
                o_qG1 <= '0;
                o_qG2 <= '0;
            end
        end
    end

    pairEnSingle: assert property (
        @(posedge clk) disable iff (reset)
        o_pairEn |=> !o_pairEn
    );

    // State moves only on a sync loss or a mode switch
    stateStep: assert property (
        @(posedge clk) disable iff (reset)
        (o_pairState != $past(o_pairState)) |->
            $past(modeChange || (i_symEn && (i_outOfSync || stepPending)))
    );

endmodule

//--- design/softDecisionMapper.sv
`timescale 1ns/10ps

module softDecisionMapper
    import viterbiPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        i_symEn,
    input  symSample_t  i_sym,
    input  scaleShift_t i_scaleShift,
    output softDec_t    o_soft
);

    localparam int SymWidth  = $bits(symSample_t);
    localparam int SoftWidth = $bits(softDec_t);
    localparam int Guard     = (1 << $bits(scaleShift_t)) - 1;
    localparam int WideWidth = SymWidth + Guard;

    logic signed [WideWidth-1:0] shifted;
    logic                        overflow;
    symSample_t                  satSym;
    softDec_t                    topBits;

    // Headroom for the largest shift, so no bit is lost before saturation
    assign shifted = {{Guard{i_sym[SymWidth-1]}}, i_sym} <<< i_scaleShift;

    // Guard bits plus the new sign must all agree
    assign overflow = (shifted[WideWidth-1:SymWidth-1] != {(Guard+1){1'b0}}) &&
                      (shifted[WideWidth-1:SymWidth-1] != {(Guard+1){1'b1}});

    always_comb begin
        if (overflow) begin
            satSym = {shifted[WideWidth-1], {(SymWidth-1){~shifted[WideWidth-1]}}};
        end
        else begin
            satSym = shifted[SymWidth-1:0];
        end
    end

    assign topBits = satSym[SymWidth-1 -: SoftWidth];

    // Positive goes 3 down to 0, negative 4 up to 7
    always_ff @(posedge clk) begin
        if (i_symEn) begin
            o_soft <= {topBits[SoftWidth-1], ~topBits[SoftWidth-2:0]};
        end
    end

    // Decoders and pairer rely on the decision holding between strobes
    softHold: assert property (
        @(posedge clk) disable iff (reset)
        !i_symEn |=> $stable(o_soft)
    );

endmodule

//--- design/sprtSyncDetector.sv
`timescale 1ns/10ps

`include "viterbiDefines.svh"

module sprtSyncDetector
    import viterbiPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      i_berDone,
    input  berCount_t i_berCount,
    output logic      o_inSync,
    output logic      o_outOfSync
);

    localparam sprtAcc_t StartValue  = sprtAcc_t'(`VIT_SPRT_START);
    localparam sprtAcc_t SyncLimit   = sprtAcc_t'(`VIT_SPRT_LIMIT);
    localparam sprtAcc_t Credit      = sprtAcc_t'(`VIT_SPRT_STEP);
    localparam sprtAcc_t CreditLimit = sprtAcc_t'(`VIT_SPRT_LIMIT - `VIT_SPRT_STEP);

    sprtAcc_t                       sprtAcc;
    logic signed [`VIT_BER_WIDTH:0] accExt;
    logic signed [`VIT_BER_WIDTH:0] countExt;

    // One extra bit so the count compares as unsigned
    assign accExt   = {sprtAcc[`VIT_BER_WIDTH-1], sprtAcc};
    assign countExt = {1'b0, i_berCount};

    always_ff @(posedge clk) begin
        if (reset) begin
            sprtAcc     <= StartValue;
            o_inSync    <= 1'b0;
            o_outOfSync <= 1'b0;
        end
        else begin
            o_outOfSync <= 1'b0;
            if (i_berDone) begin
                if (i_berCount == '0) begin
                    // Clean report earns credit
                    if (sprtAcc >= CreditLimit) begin
                        sprtAcc  <= SyncLimit;
                        o_inSync <= 1'b1;
                    end
                    else begin
                        sprtAcc <= sprtAcc + Credit;
                    end
                end
                else if (accExt >= countExt) begin
                    sprtAcc <= sprtAcc - sprtAcc_t'(i_berCount);
                end
                else begin
                    // Ran out of credit, restart and clear the decoders
                    sprtAcc     <= StartValue;
                    o_inSync    <= 1'b0;
                    o_outOfSync <= 1'b1;
                end
            end
        end
    end

    accRange: assert property (
        @(posedge clk) disable iff (reset)
        (sprtAcc >= 0) && (sprtAcc <= SyncLimit)
    );

endmodule

//--- design/viterbiDefines.svh
`ifndef VITERBI_DEFINES_SVH
`define VITERBI_DEFINES_SVH

// Datapath widths
`define VIT_SYM_WIDTH       18
`define VIT_SOFT_WIDTH      3
`define VIT_BER_WIDTH       16

// Mapper scale is a left shift of 0 to 7 bits
`define VIT_SHIFT_WIDTH     3

// SPRT sync test
`define VIT_SPRT_START      64
`define VIT_SPRT_LIMIT      128
`define VIT_SPRT_STEP       8

`endif

//--- design/viterbiFrontEnd.sv
`timescale 1ns/10ps

module viterbiFrontEnd
    import viterbiPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        i_symEn,
    input  symSample_t  i_iSym,
    input  symSample_t  i_qSym,
    input  scaleShift_t i_scaleShift,
    input  demodMode_t  i_mode,
    input  logic        i_berDone,
    input  berCount_t   i_berCount,
    output logic        o_pairEn,
    output softDec_t    o_iG1,
    output softDec_t    o_iG2,
    output softDec_t    o_qG1,
    output softDec_t    o_qG2,
    output logic        o_inSync,
    output logic        o_outOfSync,
    output pairState_t  o_pairState
);

    softDec_t iSoft;
    softDec_t qSoft;

    softDecisionMapper iMapper (
        .clk          (clk),
        .reset        (reset),
        .i_symEn      (i_symEn),
        .i_sym        (i_iSym),
        .i_scaleShift (i_scaleShift),
        .o_soft       (iSoft)
    );

    softDecisionMapper qMapper (
        .clk          (clk),
        .reset        (reset),
        .i_symEn      (i_symEn),
        .i_sym        (i_qSym),
        .i_scaleShift (i_scaleShift),
        .o_soft       (qSoft)
    );

    codePairer codePairer (
        .clk         (clk),
        .reset       (reset),
        .i_symEn     (i_symEn),
        .i_mode      (i_mode),
        .i_iSoft     (iSoft),
        .i_qSoft     (qSoft),
        .i_outOfSync (o_outOfSync),
        .o_pairEn    (o_pairEn),
        .o_iG1       (o_iG1),
        .o_iG2       (o_iG2),
        .o_qG1       (o_qG1),
        .o_qG2       (o_qG2),
        .o_pairState (o_pairState)
    );

    // Error reports come back from the external decoders
    sprtSyncDetector sprtSyncDetector (
        .clk         (clk),
        .reset       (reset),
        .i_berDone   (i_berDone),
        .i_berCount  (i_berCount),
        .o_inSync    (o_inSync),
        .o_outOfSync (o_outOfSync)
    );

endmodule

//--- design/viterbiPkg.sv
`include "viterbiDefines.svh"

package viterbiPkg;

    typedef logic signed [`VIT_SYM_WIDTH-1:0]   symSample_t;

    // 0 is a strong one, 7 a strong zero
    typedef logic        [`VIT_SOFT_WIDTH-1:0]  softDec_t;

    typedef logic        [`VIT_BER_WIDTH-1:0]   berCount_t;
    typedef logic signed [`VIT_BER_WIDTH-1:0]   sprtAcc_t;
    typedef logic        [`VIT_SHIFT_WIDTH-1:0] scaleShift_t;

    typedef enum logic [0:0] {
        MODE_BPSK = 1'b0,
        MODE_QPSK = 1'b1
    } demodMode_t;

    // Bit 2 is G2 inversion, bits 1:0 the phase
    // BPSK reads bit 1 as the 180 degree flip and bit 0 as G2-first
    typedef enum logic [2:0] {
        P0       = 3'd0,
        P90      = 3'd1,
        P180     = 3'd2,
        P270     = 3'd3,
        P0_INV   = 3'd4,
        P90_INV  = 3'd5,
        P180_INV = 3'd6,
        P270_INV = 3'd7
    } pairState_t;

endpackage

//--- tests/tbReference.svh
`ifndef TB_REFERENCE_SVH
`define TB_REFERENCE_SVH

// 32-bit xorshift generator
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// Saturated scaling, then 3 - floor(sample / 2^15) as offset binary
function automatic softDec_t mapSoft(input symSample_t sample, input scaleShift_t shift);
    longint maxVal;
    longint offset;
    longint scaled;
    longint top;
    maxVal = (longint'(1) << (`VIT_SYM_WIDTH - 1)) - 1;
    offset = (longint'(1) << (`VIT_SOFT_WIDTH - 1)) - 1;
    scaled = longint'(sample) <<< shift;
    if (scaled > maxVal) begin
        scaled = maxVal;
    end
    else if (scaled < -maxVal - 1) begin
        scaled = -maxVal - 1;
    end
    top = scaled >>> (`VIT_SYM_WIDTH - `VIT_SOFT_WIDTH);
    return softDec_t'(offset - top);
endfunction

function automatic logic g2Inverted(input pairState_t state);
    return state inside {P0_INV, P90_INV, P180_INV, P270_INV};
endfunction

// Returns {g1, g2}
function automatic logic [5:0] qpskPair(input pairState_t state, input softDec_t iS,
                                        input softDec_t qS);
    softDec_t g1;
    softDec_t g2;
    case (state)
        P0, P0_INV: begin
            g1 = iS;
            g2 = qS;
        end
        P90, P90_INV: begin
            g1 = qS;
            g2 = ~iS;
        end
        P180, P180_INV: begin
            g1 = ~iS;
            g2 = ~qS;
        end
        default: begin
            g1 = ~qS;
            g2 = iS;
        end
    endcase
    if (g2Inverted(state)) begin
        g2 = ~g2;
    end
    return {g1, g2};
endfunction

function automatic logic [5:0] bpskPair(input pairState_t state, input softDec_t dly,
                                        input softDec_t cur);
    softDec_t g1;
    softDec_t g2;
    g1 = dly;
    g2 = cur;
    if (state inside {P180, P270, P180_INV, P270_INV}) begin
        g1 = ~g1;
        g2 = ~g2;
    end
    if (g2Inverted(state)) begin
        g2 = ~g2;
    end
    return {g1, g2};
endfunction

// G2-first states take their pair when the toggle is clear
function automatic logic bpskCaptures(input pairState_t state, input logic toggle);
    if (state inside {P90, P270, P90_INV, P270_INV}) begin
        return !toggle;
    end
    return toggle;
endfunction

function automatic int sprtNext(input int acc, input int count, output logic lost,
                                output logic locked);
    lost = 1'b0;
    locked = 1'b0;
    if (count == 0) begin
        if (acc + `VIT_SPRT_STEP >= `VIT_SPRT_LIMIT) begin
            locked = 1'b1;
            return `VIT_SPRT_LIMIT;
        end
        return acc + `VIT_SPRT_STEP;
    end
    if (acc >= count) begin
        return acc - count;
    end
    lost = 1'b1;
    return `VIT_SPRT_START;
endfunction

`endif

//--- tests/viterbiFrontEndTb.sv
`timescale 1ns/10ps

`include "viterbiDefines.svh"

module viterbiFrontEndTb
    import viterbiPkg::*;
();

    logic        clk = 1'b0;
    logic        reset;
    logic        i_symEn;
    symSample_t  i_iSym;
    symSample_t  i_qSym;
    scaleShift_t i_scaleShift;
    demodMode_t  i_mode;
    logic        i_berDone;
    berCount_t   i_berCount;
    logic        o_pairEn;
    softDec_t    o_iG1;
    softDec_t    o_iG2;
    softDec_t    o_qG1;
    softDec_t    o_qG2;
    logic        o_inSync;
    logic        o_outOfSync;
    pairState_t  o_pairState;

    logic [31:0] rngState = 32'hdfdf3169;
    int          errorCount = 0;
    int          timeoutCount = 0;
    // Entries are {valid, qpsk, g1, g2}
    logic [7:0]  pairQueue[$];
    logic [7:0]  heldPair = 8'h00;
    demodMode_t  modelMode = MODE_QPSK;
    pairState_t  modelState = P0;
    // Already set by the first strobe in QPSK
    logic        modelToggle = 1'b1;
    logic        stepPending = 1'b0;
    softDec_t    curI;
    softDec_t    curQ;
    softDec_t    dlyI;
    logic        curValid = 1'b0;
    logic        dlyValid = 1'b0;
    int          sprtAcc = `VIT_SPRT_START;
    logic        modelInSync = 1'b0;
    logic        expLost = 1'b0;
    logic        reportDue = 1'b0;

    `include "tbReference.svh"

    viterbiFrontEnd uut (.*);

    always #10 clk = ~clk;

    task automatic nextRandom(output logic [31:0] value);
        rngState = xorshift32(rngState);
        value = rngState;
    endtask

    task automatic sendSymbol(input symSample_t iSym, input symSample_t qSym,
                              input scaleShift_t shift);
        logic [5:0] pair;
        logic       capture;
        logic       valid;
        @(posedge clk);
        i_symEn      <= 1'b1;
        i_iSym       <= iSym;
        i_qSym       <= qSym;
        i_scaleShift <= shift;
        // Pairer works on the decisions of the previous symbol
        if (modelMode == MODE_QPSK) begin
            pair    = qpskPair(modelState, curI, curQ);
            capture = 1'b1;
            valid   = curValid;
        end
        else begin
            pair    = bpskPair(modelState, dlyI, curI);
            capture = bpskCaptures(modelState, modelToggle);
            valid   = curValid && dlyValid;
        end
        if (capture) begin
            heldPair = {valid, modelMode == MODE_QPSK, pair};
        end
        if (modelToggle) begin
            pairQueue.push_back(heldPair);
        end
        if (stepPending && (modelMode == MODE_QPSK || modelToggle)) begin
            modelState  = pairState_t'(modelState + 3'd1);
            stepPending = 1'b0;
        end
        if (modelMode == MODE_BPSK) begin
            modelToggle = !modelToggle;
        end
        dlyI     = curI;
        dlyValid = curValid;
        curI     = mapSoft(iSym, shift);
        curQ     = mapSoft(qSym, shift);
        curValid = 1'b1;
        @(posedge clk);
        i_symEn <= 1'b0;
        @(negedge clk);
        assert (o_pairState == modelState) else begin
            errorCount++;
            $display("CHECK FAILED at %0t: pair state %s, expected %s", $time,
                     o_pairState.name(), modelState.name());
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic sendRandomSymbol();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        nextRandom(a);
        nextRandom(b);
        nextRandom(c);
        // Random right shift spreads magnitudes, so small and saturated values both occur
        sendSymbol(symSample_t'($signed(a[17:0]) >>> a[22:20]),
                   symSample_t'($signed(b[17:0]) >>> b[22:20]), scaleShift_t'(c[2:0]));
    endtask

    task automatic sendReport(input int count);
        logic lost;
        logic locked;
        @(posedge clk);
        i_berDone  <= 1'b1;
        i_berCount <= berCount_t'(count);
        sprtAcc = sprtNext(sprtAcc, count, lost, locked);
        expLost = lost;
        if (lost) begin
            modelInSync = 1'b0;
            stepPending = 1'b1;
        end
        else if (locked) begin
            modelInSync = 1'b1;
        end
        @(posedge clk);
        i_berDone <= 1'b0;
    endtask

    task automatic setMode(input demodMode_t mode);
        @(posedge clk);
        i_mode <= mode;
        modelMode   = mode;
        modelState  = P0;
        stepPending = 1'b0;
        if (mode == MODE_QPSK) begin
            modelToggle = 1'b1;
        end
        @(posedge clk);
    endtask

    task automatic waitPairsDrained(input int maxCycles);
        int cycles;
        cycles = 0;
        while (pairQueue.size() > 0 && cycles < maxCycles) begin
            @(posedge clk);
            cycles++;
        end
        if (pairQueue.size() > 0) begin
            timeoutCount++;
            $display("Timed out with %0d code pairs never delivered", pairQueue.size());
        end
    endtask

    always @(negedge clk) begin : pairCheck
        logic [7:0] entry;
        softDec_t   expQ1;
        softDec_t   expQ2;
        if (!reset) begin
            if (o_pairEn) begin
                assert (pairQueue.size() > 0) else begin
                    errorCount++;
                    $display("Pair strobe at %0t with no code pair expected", $time);
                end
                if (pairQueue.size() > 0) begin
                    entry = pairQueue.pop_front();
                    // Q decoder gets zeros in BPSK
                    expQ1 = entry[6] ? entry[5:3] : '0;
                    expQ2 = entry[6] ? entry[2:0] : '0;
                    assert (!entry[7] || (o_iG1 == entry[5:3] && o_iG2 == entry[2:0] &&
                                          o_qG1 == expQ1 && o_qG2 == expQ2)) else begin
                        errorCount++;
                        $display("CHECK FAILED at %0t: pair I %0d/%0d Q %0d/%0d, expected %s",
                                 $time, o_iG1, o_iG2, o_qG1, o_qG2,
                                 $sformatf("I %0d/%0d Q %0d/%0d", entry[5:3], entry[2:0],
                                           expQ1, expQ2));
                    end
                end
            end
            assert (o_outOfSync == (reportDue && expLost)) else begin
                errorCount++;
                $display("CHECK FAILED at %0t: out-of-sync is %b", $time, o_outOfSync);
            end
            assert (!reportDue || o_inSync == modelInSync) else begin
                errorCount++;
                $display("CHECK FAILED at %0t: in-sync %b, expected %b", $time,
                         o_inSync, modelInSync);
            end
            reportDue = i_berDone;
        end
    end

    initial begin
        logic [31:0] r;
        reset        = 1'b1;
        i_symEn      = 1'b0;
        i_iSym       = '0;
        i_qSym       = '0;
        i_scaleShift = '0;
        i_mode       = MODE_QPSK;
        i_berDone    = 1'b0;
        i_berCount   = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!o_pairEn && !o_outOfSync && !o_inSync && o_pairState == P0) else begin
            errorCount++;
            $display("CHECK FAILED at %0t: outputs not idle after reset", $time);
        end

        repeat (40) sendRandomSymbol();

        // Lock on the eighth clean report, then lose it
        repeat (8) sendReport(0);
        sendReport(sprtAcc + 1);
        for (int k = 0; k < 24; k++) begin
            nextRandom(r);
            sendReport((r[1:0] != 2'b00) ? 0 : int'(r[7:2]));
            repeat (2) sendRandomSymbol();
        end

        // Mode switch returns to P0, then all eight states in turn
        setMode(MODE_BPSK);
        setMode(MODE_QPSK);
        repeat (8) begin
            sendReport(16'hffff);
            repeat (3) sendRandomSymbol();
        end
        assert (o_pairState == P0) else begin
            errorCount++;
            $display("CHECK FAILED at %0t: state did not wrap to P0", $time);
        end

        setMode(MODE_BPSK);
        repeat (20) sendRandomSymbol();
        repeat (8) begin
            sendReport(16'hffff);
            repeat (5) sendRandomSymbol();
        end
        waitPairsDrained(20);

        $display("Closing with %0d failed checks and %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Everything OK");
        end
        else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
